/* Makefile */
TOP := tb_issue_read_operands

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/1ns -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* design/fu_dispatch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_cfg.svh"

module fu_dispatch
  import issue_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_uarch_ni,
  // valid and ack both high this cycle
  input  wire logic      transfer_i,
  input  wire logic      ex_valid_i,
  input  wire logic      flush_i,
  input  wire fu_t       fu_i,
  input  wire fu_op_t    op_i,
  input  wire trans_id_t trans_id_i,
  input  wire xlen_t     operand_a_i,
  input  wire xlen_t     operand_b_i,
  input  wire xlen_t     imm_i,
  // registered payload towards the units
  output xlen_t          operand_a_o,
  output xlen_t          operand_b_o,
  output xlen_t          imm_o,
  output fu_t            fu_o,
  output fu_op_t         op_o,
  output trans_id_t      trans_id_o,
  // one-cycle unit valids
  output logic           alu_valid_o,
  output logic           branch_valid_o,
  output logic           mult_valid_o,
  output logic           lsu_valid_o,
  output logic           csr_valid_o,
  output logic           mult_pending_o
);

  // ------------------------------------------------------------
  // ID/EX payload register
  // ------------------------------------------------------------
  // follows the inputs every cycle, qualified later by the valids
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      operand_a_o <= '0;
      operand_b_o <= '0;
      imm_o       <= '0;
      fu_o        <= NONE;
      op_o        <= '0;
      trans_id_o  <= '0;
    end else begin
      operand_a_o <= operand_a_i;
      operand_b_o <= operand_b_i;
      imm_o       <= imm_i;
      fu_o        <= fu_i;
      op_o        <= op_i;
      trans_id_o  <= trans_id_i;
    end
  end

  // ------------------------------------------------------------
  // unit valids
  // ------------------------------------------------------------
  // cleared by default so each valid lasts a single cycle
  // exceptions pass through without starting a unit
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      alu_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
      mult_valid_o   <= 1'b0;
      lsu_valid_o    <= 1'b0;
      csr_valid_o    <= 1'b0;
    end else begin
      alu_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
      mult_valid_o   <= 1'b0;
      lsu_valid_o    <= 1'b0;
      csr_valid_o    <= 1'b0;
      if (transfer_i && !ex_valid_i && !flush_i) begin
        case (fu_i)
          ALU:         alu_valid_o    <= 1'b1;
          CTRL_FLOW:   branch_valid_o <= 1'b1;
          MULT:        mult_valid_o   <= 1'b1;
          LOAD, STORE: lsu_valid_o    <= 1'b1;
          CSR:         csr_valid_o    <= 1'b1;
          default:     ;
        endcase
      end
    end
  end

  // fed back to the arbiter for the shared result bus
  assign mult_pending_o = mult_valid_o;

endmodule

`default_nettype wire

/* design/int_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_cfg.svh"

module int_regfile
  import issue_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         rst_uarch_ni,
  // two read ports, one per source operand
  input  wire reg_addr_t                    raddr_a_i,
  input  wire reg_addr_t                    raddr_b_i,
  output xlen_t                             rdata_a_o,
  output xlen_t                             rdata_b_o,
  // commit write ports
  input  wire reg_addr_t [`ISS_NR_COMMIT-1:0] waddr_i,
  input  wire xlen_t     [`ISS_NR_COMMIT-1:0] wdata_i,
  input  wire logic      [`ISS_NR_COMMIT-1:0] we_i
);

  xlen_t regs_q [`ISS_NR_REGS];

  // ------------------------------------------------------------
  // write side
  // ------------------------------------------------------------
  // ports are walked in order, so the highest port wins a collision
  // x0 is skipped and keeps its reset value of zero
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      for (int unsigned r = 0; r < `ISS_NR_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      for (int unsigned p = 0; p < `ISS_NR_COMMIT; p++) begin
        if (we_i[p] && (waddr_i[p] != '0)) begin
          regs_q[waddr_i[p]] <= wdata_i[p];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // read side
  // ------------------------------------------------------------
  // combinational, a write becomes visible the cycle after the edge
  // x0 decoded explicitly so it reads zero regardless of storage
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

/* design/issue_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_cfg.svh"

module issue_arbiter
  import issue_pkg::*;
(
  input  wire logic                           issue_valid_i,
  input  wire fu_t                            fu_i,
  input  wire reg_addr_t                      rd_i,
  input  wire logic                           ex_valid_i,
  input  wire fu_t       [`ISS_NR_REGS-1:0]   rd_clobber_i,
  // commit ports, only address and enable matter here
  input  wire reg_addr_t [`ISS_NR_COMMIT-1:0] waddr_i,
  input  wire logic      [`ISS_NR_COMMIT-1:0] we_i,
  input  wire logic                           operand_stall_i,
  input  wire logic                           flu_ready_i,
  input  wire logic                           lsu_ready_i,
  // a multiply was dispatched last cycle
  input  wire logic                           mult_pending_i,
  output logic                                issue_ack_o
);

  logic fu_busy;
  logic rd_free;

  // readiness of the unit this instruction needs
  // fixed latency units share one ready, load and store share the LSU
  always_comb begin : unit_busy
    unique case (fu_i)
      ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~flu_ready_i;
      LOAD, STORE:               fu_busy = ~lsu_ready_i;
      default:                   fu_busy = 1'b0;
    endcase
  end

  // ------------------------------------------------------------
  // WAW check
  // ------------------------------------------------------------
  // rd is free when nobody claims it, or when the current owner
  // retires through a commit port in this very cycle
  always_comb begin : waw_check
    rd_free = (rd_clobber_i[rd_i] == NONE);
    for (int unsigned i = 0; i < `ISS_NR_COMMIT; i++) begin
      if (we_i[i] && (waddr_i[i] == rd_i)) begin
        rd_free = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // acknowledge
  // ------------------------------------------------------------
  always_comb begin : issue_ack
    issue_ack_o = 1'b0;
    if (issue_valid_i) begin
      if (!operand_stall_i && !fu_busy && rd_free) begin
        issue_ack_o = 1'b1;
      end
      // exceptions and unit-less instructions need no unit and no operands
      if (ex_valid_i || (fu_i == NONE)) begin
        issue_ack_o = 1'b1;
      end
    end
    // multiplier and the other fixed latency units share a result bus,
    // so they may not follow a multiply back to back
    if (mult_pending_i && (fu_i inside {ALU, CTRL_FLOW, CSR})) begin
      issue_ack_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/issue_cfg.svh */
`ifndef ISS_CFG_SVH
`define ISS_CFG_SVH

// integer datapath width
`define ISS_XLEN 32

// integer register file size and index width
`define ISS_NR_REGS 32
`define ISS_REG_ADDR_W 5

// write ports coming back from the commit stage
`define ISS_NR_COMMIT 2

// scoreboard tag and opaque operation code widths
`define ISS_TRANS_ID_W 3
`define ISS_OP_W 6

`endif

/* design/issue_pkg.sv */
`default_nettype none

`include "issue_cfg.svh"

package issue_pkg;

  // one integer data word
  typedef logic [`ISS_XLEN-1:0] xlen_t;

  // index into the integer register file
  typedef logic [`ISS_REG_ADDR_W-1:0] reg_addr_t;

  // scoreboard entry tag, travels with the instruction to the unit
  typedef logic [`ISS_TRANS_ID_W-1:0] trans_id_t;

  // operation code, not decoded here
  typedef logic [`ISS_OP_W-1:0] fu_op_t;

  // functional units, NONE also marks a free entry in the clobber table
  typedef enum logic [2:0] {
    NONE,
    LOAD,
    STORE,
    ALU,
    CTRL_FLOW,
    MULT,
    CSR
  } fu_t;

endpackage

`default_nettype wire

/* design/issue_read_operands.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_cfg.svh"

module issue_read_operands
  import issue_pkg::*;
(
  input  wire logic                           clk_i,
  input  wire logic                           rst_uarch_ni,
  // decoded instruction from the scoreboard
  input  wire logic                           issue_valid_i,
  input  wire fu_t                            issue_fu_i,
  input  wire fu_op_t                         issue_op_i,
  input  wire reg_addr_t                      issue_rs1_i,
  input  wire reg_addr_t                      issue_rs2_i,
  input  wire reg_addr_t                      issue_rd_i,
  input  wire xlen_t                          issue_imm_i,
  input  wire xlen_t                          issue_pc_i,
  input  wire trans_id_t                      issue_trans_id_i,
  input  wire logic                           issue_use_pc_i,
  input  wire logic                           issue_use_imm_i,
  input  wire logic                           issue_use_zimm_i,
  input  wire logic                           issue_ex_valid_i,
  output logic                                issue_ack_o,
  // scoreboard clobber table and forward poll
  input  wire fu_t       [`ISS_NR_REGS-1:0]   rd_clobber_i,
  output reg_addr_t                           rs1_o,
  output reg_addr_t                           rs2_o,
  input  wire xlen_t                          rs1_fwd_i,
  input  wire logic                           rs1_fwd_valid_i,
  input  wire xlen_t                          rs2_fwd_i,
  input  wire logic                           rs2_fwd_valid_i,
  // commit write ports
  input  wire reg_addr_t [`ISS_NR_COMMIT-1:0] waddr_i,
  input  wire xlen_t     [`ISS_NR_COMMIT-1:0] wdata_i,
  input  wire logic      [`ISS_NR_COMMIT-1:0] we_i,
  // control and unit readiness
  input  wire logic                           flush_i,
  input  wire logic                           stall_i,
  input  wire logic                           flu_ready_i,
  input  wire logic                           lsu_ready_i,
  // unregistered operands
  output xlen_t                               rs1_forwarding_o,
  output xlen_t                               rs2_forwarding_o,
  // registered payload and unit valids
  output xlen_t                               operand_a_o,
  output xlen_t                               operand_b_o,
  output xlen_t                               imm_o,
  output fu_t                                 fu_o,
  output fu_op_t                              op_o,
  output trans_id_t                           trans_id_o,
  output logic                                alu_valid_o,
  output logic                                branch_valid_o,
  output logic                                mult_valid_o,
  output logic                                lsu_valid_o,
  output logic                                csr_valid_o
);

  xlen_t rdata_a;
  xlen_t rdata_b;
  xlen_t operand_a_n;
  xlen_t operand_b_n;
  xlen_t imm_n;
  logic  forward_rs1;
  logic  forward_rs2;
  logic  operand_stall;
  logic  mult_pending;
  logic  transfer;

  // source indices go straight to the scoreboard for the forward lookup
  assign rs1_o    = issue_rs1_i;
  assign rs2_o    = issue_rs2_i;
  assign transfer = issue_valid_i && issue_ack_o;

  // operand mux output before the ID/EX register
  assign rs1_forwarding_o = operand_a_n;
  assign rs2_forwarding_o = operand_b_n;

  // ------------------------------------------------------------
  // register file and hazard checks
  // ------------------------------------------------------------
  int_regfile u_regfile (
    .clk_i        (clk_i),
    .rst_uarch_ni (rst_uarch_ni),
    .raddr_a_i    (issue_rs1_i),
    .raddr_b_i    (issue_rs2_i),
    .rdata_a_o    (rdata_a),
    .rdata_b_o    (rdata_b),
    .waddr_i      (waddr_i),
    .wdata_i      (wdata_i),
    .we_i         (we_i)
  );

  operand_hazard u_hazard (
    .rs1_i           (issue_rs1_i),
    .rs2_i           (issue_rs2_i),
    .use_zimm_i      (issue_use_zimm_i),
    .rd_clobber_i    (rd_clobber_i),
    .rs1_fwd_valid_i (rs1_fwd_valid_i),
    .rs2_fwd_valid_i (rs2_fwd_valid_i),
    .stall_i         (stall_i),
    .forward_rs1_o   (forward_rs1),
    .forward_rs2_o   (forward_rs2),
    .operand_stall_o (operand_stall)
  );

  issue_arbiter u_arbiter (
    .issue_valid_i   (issue_valid_i),
    .fu_i            (issue_fu_i),
    .rd_i            (issue_rd_i),
    .ex_valid_i      (issue_ex_valid_i),
    .rd_clobber_i    (rd_clobber_i),
    .waddr_i         (waddr_i),
    .we_i            (we_i),
    .operand_stall_i (operand_stall),
    .flu_ready_i     (flu_ready_i),
    .lsu_ready_i     (lsu_ready_i),
    .mult_pending_i  (mult_pending),
    .issue_ack_o     (issue_ack_o)
  );

  // ------------------------------------------------------------
  // operand build and dispatch
  // ------------------------------------------------------------
  operand_select u_select (
    .fu_i          (issue_fu_i),
    .rs1_i         (issue_rs1_i),
    .pc_i          (issue_pc_i),
    .imm_i         (issue_imm_i),
    .use_pc_i      (issue_use_pc_i),
    .use_zimm_i    (issue_use_zimm_i),
    .use_imm_i     (issue_use_imm_i),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .rs1_fwd_i     (rs1_fwd_i),
    .rs2_fwd_i     (rs2_fwd_i),
    .forward_rs1_i (forward_rs1),
    .forward_rs2_i (forward_rs2),
    .operand_a_o   (operand_a_n),
    .operand_b_o   (operand_b_n),
    .imm_o         (imm_n)
  );

  fu_dispatch u_dispatch (
    .clk_i          (clk_i),
    .rst_uarch_ni   (rst_uarch_ni),
    .transfer_i     (transfer),
    .ex_valid_i     (issue_ex_valid_i),
    .flush_i        (flush_i),
    .fu_i           (issue_fu_i),
    .op_i           (issue_op_i),
    .trans_id_i     (issue_trans_id_i),
    .operand_a_i    (operand_a_n),
    .operand_b_i    (operand_b_n),
    .imm_i          (imm_n),
    .operand_a_o    (operand_a_o),
    .operand_b_o    (operand_b_o),
    .imm_o          (imm_o),
    .fu_o           (fu_o),
    .op_o           (op_o),
    .trans_id_o     (trans_id_o),
    .alu_valid_o    (alu_valid_o),
    .branch_valid_o (branch_valid_o),
    .mult_valid_o   (mult_valid_o),
    .lsu_valid_o    (lsu_valid_o),
    .csr_valid_o    (csr_valid_o),
    .mult_pending_o (mult_pending)
  );

endmodule

`default_nettype wire

/* design/operand_hazard.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_cfg.svh"

module operand_hazard
  import issue_pkg::*;
(
  input  wire reg_addr_t                 rs1_i,
  input  wire reg_addr_t                 rs2_i,
  // rs1 field holds an immediate, no register read
  input  wire logic                      use_zimm_i,
  // writer of each register, NONE when nothing is in flight
  input  wire fu_t [`ISS_NR_REGS-1:0]    rd_clobber_i,
  input  wire logic                      rs1_fwd_valid_i,
  input  wire logic                      rs2_fwd_valid_i,
  // external stall request
  input  wire logic                      stall_i,
  output logic                           forward_rs1_o,
  output logic                           forward_rs2_o,
  output logic                           operand_stall_o
);

  fu_t  rs1_writer;
  fu_t  rs2_writer;
  logic rs1_pending;
  logic rs2_pending;

  // look up who will write each source
  assign rs1_writer = rd_clobber_i[rs1_i];
  assign rs2_writer = rd_clobber_i[rs2_i];

  // zimm means rs1 is a constant, so it never waits
  assign rs1_pending = !use_zimm_i && (rs1_writer != NONE);
  assign rs2_pending = (rs2_writer != NONE);

  // ------------------------------------------------------------
  // forward decision
  // ------------------------------------------------------------
  // the scoreboard must already hold the result
  // CSR results only reach us through the register file
  assign forward_rs1_o = rs1_pending && rs1_fwd_valid_i && (rs1_writer != CSR);
  assign forward_rs2_o = rs2_pending && rs2_fwd_valid_i && (rs2_writer != CSR);

  // pending source that cannot be forwarded holds the instruction
  assign operand_stall_o = stall_i
                         || (rs1_pending && !forward_rs1_o)
                         || (rs2_pending && !forward_rs2_o);

endmodule

`default_nettype wire

/* design/operand_select.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_cfg.svh"

module operand_select
  import issue_pkg::*;
(
  input  wire fu_t       fu_i,
  input  wire reg_addr_t rs1_i,
  input  wire xlen_t     pc_i,
  input  wire xlen_t     imm_i,
  input  wire logic      use_pc_i,
  input  wire logic      use_zimm_i,
  input  wire logic      use_imm_i,
  // register file read data
  input  wire xlen_t     rdata_a_i,
  input  wire xlen_t     rdata_b_i,
  // scoreboard forward values and their select
  input  wire xlen_t     rs1_fwd_i,
  input  wire xlen_t     rs2_fwd_i,
  input  wire logic      forward_rs1_i,
  input  wire logic      forward_rs2_i,
  output xlen_t          operand_a_o,
  output xlen_t          operand_b_o,
  output xlen_t          imm_o
);

  // ------------------------------------------------------------
  // operand mux, later overrides win
  // ------------------------------------------------------------
  always_comb begin : operand_mux
    // start from the register file
    operand_a_o = rdata_a_i;
    operand_b_o = rdata_b_i;
    if (forward_rs1_i) begin
      operand_a_o = rs1_fwd_i;
    end
    if (forward_rs2_i) begin
      operand_b_o = rs2_fwd_i;
    end
    // auipc, jal and friends
    if (use_pc_i) begin
      operand_a_o = pc_i;
    end
    // csr immediate forms, rs1 field zero extended
    if (use_zimm_i) begin
      operand_a_o = {{(`ISS_XLEN - `ISS_REG_ADDR_W){1'b0}}, rs1_i};
    end
    // stores and branches carry rs2 in b and the offset in imm
    if (use_imm_i && (fu_i != STORE) && (fu_i != CTRL_FLOW)) begin
      operand_b_o = imm_i;
    end
  end

  // immediate always goes out unchanged
  assign imm_o = imm_i;

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_uarch_no
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 3;

  // free running 100 ns clock
  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // reset held over three rising edges
  // released on the following falling edge, away from the capture edge
  initial begin
    rst_uarch_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_uarch_no = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tb_issue_read_operands.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_cfg.svh"

module tb_issue_read_operands
  import issue_pkg::*;
();

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 400;
  // all tests plus reset, with some slack on top
  localparam int CYCLE_LIMIT     = NUM_TESTS * CYCLES_PER_TEST + 600;

  logic clk;
  logic rst_n;

  // scoreboard side stimulus
  logic      issue_valid, issue_use_pc, issue_use_imm, issue_use_zimm, issue_ex_valid;
  fu_t       issue_fu;
  fu_op_t    issue_op;
  reg_addr_t issue_rs1, issue_rs2, issue_rd;
  xlen_t     issue_imm, issue_pc;
  trans_id_t issue_trans_id;
  fu_t       [`ISS_NR_REGS-1:0]   rd_clobber;
  xlen_t     rs1_fwd, rs2_fwd;
  logic      rs1_fwd_valid, rs2_fwd_valid;
  reg_addr_t [`ISS_NR_COMMIT-1:0] waddr;
  xlen_t     [`ISS_NR_COMMIT-1:0] wdata;
  logic      [`ISS_NR_COMMIT-1:0] we;
  logic      flush, stall, flu_ready, lsu_ready;

  // DUT outputs
  logic      issue_ack;
  reg_addr_t rs1_out, rs2_out;
  xlen_t     rs1_forwarding, rs2_forwarding, operand_a, operand_b, imm_out;
  fu_t       fu_out;
  fu_op_t    op_out;
  trans_id_t trans_id_out;
  logic      alu_valid, branch_valid, mult_valid, lsu_valid, csr_valid;

  // reference model state
  xlen_t     model_regs [`ISS_NR_REGS];
  logic      mult_pend_m = 1'b0;
  logic      hold = 1'b0;
  logic      have_prev = 1'b0;
  // expected registered outputs after the next edge
  xlen_t     exp_a, exp_b, exp_imm;
  fu_t       exp_fu;
  fu_op_t    exp_op;
  trans_id_t exp_tid;
  logic [4:0] exp_valids;

  integer seed = 32'h3d2;
  int     errors = 0;
  int     checks = 0;
  int     transfers;
  int     cycle_cnt = 0;

  // per test stimulus bias, a divider n means about one in n
  int     clob_div, fwd_div, ready_div, flush_div, ex_div, use_div, stall_div;
  logic   waw_mode, mult_mode;
  string  mode_name;

  tb_clock_gen u_clk (
    .clk_o        (clk),
    .rst_uarch_no (rst_n)
  );

  issue_read_operands UUT (
    .clk_i            (clk),
    .rst_uarch_ni     (rst_n),
    .issue_valid_i    (issue_valid),
    .issue_fu_i       (issue_fu),
    .issue_op_i       (issue_op),
    .issue_rs1_i      (issue_rs1),
    .issue_rs2_i      (issue_rs2),
    .issue_rd_i       (issue_rd),
    .issue_imm_i      (issue_imm),
    .issue_pc_i       (issue_pc),
    .issue_trans_id_i (issue_trans_id),
    .issue_use_pc_i   (issue_use_pc),
    .issue_use_imm_i  (issue_use_imm),
    .issue_use_zimm_i (issue_use_zimm),
    .issue_ex_valid_i (issue_ex_valid),
    .issue_ack_o      (issue_ack),
    .rd_clobber_i     (rd_clobber),
    .rs1_o            (rs1_out),
    .rs2_o            (rs2_out),
    .rs1_fwd_i        (rs1_fwd),
    .rs1_fwd_valid_i  (rs1_fwd_valid),
    .rs2_fwd_i        (rs2_fwd),
    .rs2_fwd_valid_i  (rs2_fwd_valid),
    .waddr_i          (waddr),
    .wdata_i          (wdata),
    .we_i             (we),
    .flush_i          (flush),
    .stall_i          (stall),
    .flu_ready_i      (flu_ready),
    .lsu_ready_i      (lsu_ready),
    .rs1_forwarding_o (rs1_forwarding),
    .rs2_forwarding_o (rs2_forwarding),
    .operand_a_o      (operand_a),
    .operand_b_o      (operand_b),
    .imm_o            (imm_out),
    .fu_o             (fu_out),
    .op_o             (op_out),
    .trans_id_o       (trans_id_out),
    .alu_valid_o      (alu_valid),
    .branch_valid_o   (branch_valid),
    .mult_valid_o     (mult_valid),
    .lsu_valid_o      (lsu_valid),
    .csr_valid_o      (csr_valid)
  );

  // ------------------------------------------------------------
  // random helpers
  // ------------------------------------------------------------
  function automatic int unsigned rnd_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // n of zero never fires
  function automatic logic chance(input int unsigned n);
    if (n == 0) return 1'b0;
    return rnd_below(n) == 0;
  endfunction

  // first of one skips NONE
  function automatic fu_t rand_fu(input int unsigned first);
    logic [2:0] code;
    code = 3'(first + rnd_below(7 - first));
    return fu_t'(code);
  endfunction

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns %s", $time, msg);
    errors++;
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  task automatic set_mode(input int mode);
    clob_div  = 16;
    fwd_div   = 4;
    ready_div = 8;
    flush_div = 16;
    ex_div    = 16;
    use_div   = 4;
    stall_div = 16;
    waw_mode  = 1'b0;
    mult_mode = 1'b0;
    case (mode)
      0: begin
        mode_name = "register file";
        clob_div  = 0;
        use_div   = 0;
        ex_div    = 0;
        stall_div = 0;
      end
      1: begin
        mode_name = "forwarding";
        clob_div  = 3;
        fwd_div   = 2;
      end
      2: begin
        mode_name = "waw";
        clob_div  = 3;
        fwd_div   = 0;
        waw_mode  = 1'b1;
      end
      3: begin
        mode_name = "back-pressure";
        ready_div = 2;
        mult_mode = 1'b1;
      end
      4: begin
        mode_name = "dispatch";
        ex_div    = 4;
        flush_div = 4;
      end
      default: begin
        mode_name = "operand select";
        use_div   = 2;
      end
    endcase
  endtask

  // commit writes seen on the last rising edge, higher port last
  task automatic apply_commits();
    for (int p = 0; p < `ISS_NR_COMMIT; p++) begin
      if (we[p] && (waddr[p] != '0)) model_regs[waddr[p]] = wdata[p];
    end
  endtask

  task automatic drive_inputs();
    // a waiting instruction keeps its fields until it is taken
    if (!hold) begin
      issue_valid    = !chance(8);
      issue_fu       = (mult_mode && chance(2)) ? MULT : rand_fu(0);
      issue_op       = fu_op_t'($random(seed));
      issue_rs1      = reg_addr_t'(rnd_below(`ISS_NR_REGS));
      issue_rs2      = reg_addr_t'(rnd_below(`ISS_NR_REGS));
      issue_rd       = reg_addr_t'(rnd_below(`ISS_NR_REGS));
      issue_imm      = xlen_t'($random(seed));
      issue_pc       = xlen_t'($random(seed));
      issue_trans_id = trans_id_t'($random(seed));
      issue_use_pc   = chance(use_div);
      issue_use_imm  = chance(use_div);
      issue_use_zimm = chance(use_div);
      issue_ex_valid = chance(ex_div);
    end
    // environment changes every cycle
    for (int r = 0; r < `ISS_NR_REGS; r++) begin
      rd_clobber[r] = chance(clob_div) ? rand_fu(1) : NONE;
    end
    rs1_fwd       = xlen_t'($random(seed));
    rs2_fwd       = xlen_t'($random(seed));
    rs1_fwd_valid = !chance(fwd_div);
    rs2_fwd_valid = !chance(fwd_div);
    for (int p = 0; p < `ISS_NR_COMMIT; p++) begin
      waddr[p] = (waw_mode && chance(2)) ? issue_rd : reg_addr_t'(rnd_below(`ISS_NR_REGS));
      wdata[p] = xlen_t'($random(seed));
      we[p]    = chance(2);
    end
    flush     = chance(flush_div);
    stall     = chance(stall_div);
    flu_ready = !chance(ready_div);
    lsu_ready = !chance(ready_div);
  endtask

  // ------------------------------------------------------------
  // reference model and checks
  // ------------------------------------------------------------
  task automatic check_comb();
    fu_t   w1;
    fu_t   w2;
    logic  pend1, pend2, fwd1, fwd2, op_stall, busy, rd_free, ack, dispatch;
    xlen_t a;
    xlen_t b;
    w1    = rd_clobber[issue_rs1];
    w2    = rd_clobber[issue_rs2];
    pend1 = !issue_use_zimm && (w1 != NONE);
    pend2 = (w2 != NONE);
    // CSR results are never forwarded
    fwd1  = pend1 && rs1_fwd_valid && (w1 != CSR);
    fwd2  = pend2 && rs2_fwd_valid && (w2 != CSR);
    op_stall = stall || (pend1 && !fwd1) || (pend2 && !fwd2);
    busy = 1'b0;
    if ((issue_fu == LOAD) || (issue_fu == STORE)) busy = !lsu_ready;
    else if (issue_fu != NONE) busy = !flu_ready;
    rd_free = (rd_clobber[issue_rd] == NONE);
    for (int p = 0; p < `ISS_NR_COMMIT; p++) begin
      if (we[p] && (waddr[p] == issue_rd)) rd_free = 1'b1;
    end
    ack = issue_valid && ((!op_stall && !busy && rd_free) || issue_ex_valid || (issue_fu == NONE));
    if (mult_pend_m && ((issue_fu == ALU) || (issue_fu == CTRL_FLOW) || (issue_fu == CSR))) begin
      ack = 1'b0;
    end
    // operand build, later sources override earlier ones
    a = fwd1 ? rs1_fwd : model_regs[issue_rs1];
    b = fwd2 ? rs2_fwd : model_regs[issue_rs2];
    if (issue_use_pc) a = issue_pc;
    if (issue_use_zimm) a = xlen_t'(issue_rs1);
    if (issue_use_imm && (issue_fu != STORE) && (issue_fu != CTRL_FLOW)) b = issue_imm;

    checks += 5;
    if (issue_ack !== ack) begin
      report_mismatch($sformatf("issue_ack_o is %0b, expected %0b (fu %s)", issue_ack, ack,
                                issue_fu.name()));
    end
    if ((rs1_out !== issue_rs1) || (rs2_out !== issue_rs2)) begin
      report_mismatch($sformatf("rs1_o/rs2_o are %0d/%0d, expected %0d/%0d", rs1_out, rs2_out,
                                issue_rs1, issue_rs2));
    end
    if (rs1_forwarding !== a) begin
      report_mismatch($sformatf("rs1_forwarding_o is %h, expected %h", rs1_forwarding, a));
    end
    if (rs2_forwarding !== b) begin
      report_mismatch($sformatf("rs2_forwarding_o is %h, expected %h", rs2_forwarding, b));
    end
    if (fu_out !== exp_fu && have_prev) begin
      report_mismatch($sformatf("fu_o is %s, expected %s", fu_out.name(), exp_fu.name()));
    end

    // what the next edge must capture
    dispatch   = ack && !issue_ex_valid && !flush;
    exp_a      = a;
    exp_b      = b;
    exp_imm    = issue_imm;
    exp_fu     = issue_fu;
    exp_op     = issue_op;
    exp_tid    = issue_trans_id;
    exp_valids = {dispatch && (issue_fu == ALU), dispatch && (issue_fu == CTRL_FLOW),
                  dispatch && (issue_fu == MULT),
                  dispatch && ((issue_fu == LOAD) || (issue_fu == STORE)),
                  dispatch && (issue_fu == CSR)};
    mult_pend_m = dispatch && (issue_fu == MULT);
    if (ack) transfers++;
    hold      = issue_valid && !ack;
    have_prev = 1'b1;
  endtask

  task automatic check_registered();
    checks += 3;
    if ({alu_valid, branch_valid, mult_valid, lsu_valid, csr_valid} !== exp_valids) begin
      report_mismatch($sformatf("valids alu/br/mul/lsu/csr are %b, expected %b",
                      {alu_valid, branch_valid, mult_valid, lsu_valid, csr_valid}, exp_valids));
    end
    if ((operand_a !== exp_a) || (operand_b !== exp_b) || (imm_out !== exp_imm)) begin
      report_mismatch($sformatf("operands a/b/imm are %h/%h/%h, expected %h/%h/%h",
                      operand_a, operand_b, imm_out, exp_a, exp_b, exp_imm));
    end
    if ((trans_id_out !== exp_tid) || (op_out !== exp_op)) begin
      report_mismatch($sformatf("trans_id_o/op_o are %0d/%h, expected %0d/%h",
                      trans_id_out, op_out, exp_tid, exp_op));
    end
  endtask

  task automatic run_test(input int mode);
    int errors_before;
    set_mode(mode);
    errors_before = errors;
    transfers     = 0;
    repeat (CYCLES_PER_TEST) begin
      @(negedge clk);
      if (have_prev) check_registered();
      apply_commits();
      drive_inputs();
      // combinational outputs settle well before the rising edge
      #10;
      check_comb();
    end
    $display("%s test %0d (%s): %0d transfers, %0d errors",
             (errors == errors_before) ? "[PASS]" : "[FAIL]", mode, mode_name, transfers,
             errors - errors_before);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    for (int r = 0; r < `ISS_NR_REGS; r++) begin
      model_regs[r] = '0;
      rd_clobber[r] = NONE;
    end
    issue_valid    = 1'b0;
    issue_fu       = NONE;
    issue_op       = '0;
    issue_rs1      = '0;
    issue_rs2      = '0;
    issue_rd       = '0;
    issue_imm      = '0;
    issue_pc       = '0;
    issue_trans_id = '0;
    issue_use_pc   = 1'b0;
    issue_use_imm  = 1'b0;
    issue_use_zimm = 1'b0;
    issue_ex_valid = 1'b0;
    rs1_fwd        = '0;
    rs2_fwd        = '0;
    rs1_fwd_valid  = 1'b0;
    rs2_fwd_valid  = 1'b0;
    waddr          = '0;
    wdata          = '0;
    we             = '0;
    flush          = 1'b0;
    stall          = 1'b0;
    flu_ready      = 1'b1;
    lsu_ready      = 1'b1;
    wait (rst_n === 1'b1);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog on the clock
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
design/issue_pkg.sv
design/int_regfile.sv
design/operand_hazard.sv
design/issue_arbiter.sv
design/operand_select.sv
design/fu_dispatch.sv
design/issue_read_operands.sv
testbench/tb_clock_gen.sv
testbench/tb_issue_read_operands.sv
